// File: flist.f
hdl/ctrl_pkg.sv
hdl/ctrl_exc_if.sv
hdl/ctrl_irq_if.sv
hdl/ctrl_exc_detect.sv
hdl/ctrl_irq_prio.sv
hdl/ctrl_fsm.sv
hdl/ctrl_top.sv
sim/ctrl_assertions.sv
sim/tb_ctrl_top.sv

// File: hdl/ctrl_exc_detect.sv
/*
 * exception detector
 * qualifies decoder flags, finds privilege violations, flops exception requests
 */

`timescale 1ns/1ps

module ctrl_exc_detect (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                instr_valid_i,
  input  logic                illegal_insn_i,
  input  logic                ecall_insn_i,
  input  logic                mret_insn_i,
  input  logic                wfi_insn_i,
  input  logic                ebrk_insn_i,
  input  logic                instr_fetch_err_i,
  input  ctrl_pkg::priv_lvl_e priv_mode_i,
  input  logic                csr_mstatus_tw_i,
  ctrl_exc_if.detector        exc
);
  import ctrl_pkg::*;

  logic illegal_insn;
  logic illegal_umode;
  logic illegal_d;
  logic exc_req_d;
  logic in_flush;
  logic exc_req_q;
  logic illegal_q;

  // decoder flags ignore instr valid so they are masked here
  assign exc.ecall     = ecall_insn_i & instr_valid_i;
  assign exc.ebrk      = ebrk_insn_i & instr_valid_i;
  assign exc.mret      = mret_insn_i & instr_valid_i;
  assign exc.wfi       = wfi_insn_i & instr_valid_i;
  assign exc.fetch_err = instr_fetch_err_i & instr_valid_i;
  assign illegal_insn  = illegal_insn_i & instr_valid_i;

  // mret needs M-mode and so does wfi when mstatus.TW traps it
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) &
                         (exc.mret | (csr_mstatus_tw_i & exc.wfi));

  // requests drop in FLUSH so a handled trap is not seen twice
  assign in_flush  = (exc.state == FLUSH);
  assign illegal_d = (illegal_insn | illegal_umode) & ~in_flush;
  assign exc_req_d = (exc.ecall | exc.ebrk | exc.fetch_err | illegal_d) & ~in_flush;

  // anything that has to go through FLUSH
  assign exc.special_req = exc.mret | exc.wfi | exc_req_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exc_req_q <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      exc_req_q <= exc_req_d;
      illegal_q <= illegal_d;
    end
  end

  assign exc.exc_req_q = exc_req_q;
  assign exc.illegal_q = illegal_q;

endmodule

// File: hdl/ctrl_exc_if.sv
/*
 * exception bus from the exception detector to the controller FSM
 */

`timescale 1ns/1ps

interface ctrl_exc_if;
  import ctrl_pkg::*;

  // valid-qualified instruction events
  logic ecall;
  logic ebrk;
  logic mret;
  logic wfi;
  logic fetch_err;
  // registered requests seen by the FSM in FLUSH
  logic exc_req_q;
  logic illegal_q;
  logic special_req;
  // FSM state back to the detector
  ctrl_fsm_e state;

  modport detector (
    output ecall, ebrk, mret, wfi, fetch_err, exc_req_q, illegal_q, special_req,
    input  state
  );

  modport fsm (
    input  ecall, ebrk, mret, wfi, fetch_err, exc_req_q, illegal_q, special_req,
    output state
  );

endinterface

// File: hdl/ctrl_fsm.sv
/*
 * controller state machine
 * boot, redirects, traps, interrupts, sleep and IF/ID stall/flush control
 */

`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        fetch_enable_i,
  input  logic                        instr_valid_i,
  input  logic [ctrl_pkg::xlen-1:0]   instr_i,
  input  logic [ctrl_pkg::xlen-1:0]   pc_id_i,
  input  ctrl_pkg::priv_lvl_e         priv_mode_i,
  input  logic                        branch_set_i,
  input  logic                        jump_set_i,
  input  logic                        stall_id_i,
  input  logic                        irq_nm_i,
  input  logic                        csr_mip_any_i,
  ctrl_exc_if.fsm                     exc,
  ctrl_irq_if.fsm                     irq,
  output logic                        ctrl_busy_o,
  output logic                        instr_req_o,
  output logic                        pc_set_o,
  output ctrl_pkg::pc_sel_e           pc_mux_o,
  output ctrl_pkg::exc_pc_sel_e       exc_pc_mux_o,
  output ctrl_pkg::exc_cause_e        exc_cause_o,
  output logic                        csr_save_if_o,
  output logic                        csr_save_id_o,
  output logic                        csr_save_cause_o,
  output logic                        csr_restore_mret_o,
  output logic [ctrl_pkg::xlen-1:0]   csr_mtval_o,
  output logic                        id_in_ready_o,
  output logic                        instr_valid_clear_o,
  output logic                        flush_id_o
);
  import ctrl_pkg::*;

  ctrl_fsm_e state_q, state_d;
  logic      nmi_mode_q, nmi_mode_d;
  logic      halt_if;
  logic      flush_id;

  always_comb begin
    state_d            = state_q;
    nmi_mode_d         = nmi_mode_q;
    instr_req_o        = 1'b1;
    ctrl_busy_o        = 1'b1;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_pc_mux_o       = EXC_PC_IRQ;
    exc_cause_o        = exc_cause_e'(6'd0);
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    csr_mtval_o        = '0;
    halt_if            = 1'b0;
    flush_id           = 1'b0;

    unique case (state_q)
      RESET: begin
        // hold boot address until fetch is enabled
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end
      BOOT_SET: begin
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end
      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // wake on any pending bit even when it is not enabled
        if (irq_nm_i || csr_mip_any_i) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end
      FIRST_FETCH: begin
        // halt_if is still low here so ready is just not stalled
        if (!stall_id_i) begin
          state_d = DECODE;
        end
        // pipeline is empty after boot or sleep so the irq goes at once
        if (irq.handle_irq) begin
          state_d  = IRQ_TAKEN;
          halt_if  = 1'b1;
          flush_id = 1'b1;
        end
      end
      DECODE: begin
        // mux set early and only used with pc_set
        pc_mux_o = PC_JUMP;
        if (instr_valid_i) begin
          if (exc.special_req) begin
            // keep the instruction in ID for FLUSH
            state_d = FLUSH;
            halt_if = 1'b1;
          end else if (branch_set_i || jump_set_i) begin
            pc_set_o = 1'b1;
          end
          // irq waits for a multicycle instruction to finish
          if (irq.handle_irq && stall_id_i) begin
            halt_if = 1'b1;
          end
        end
        if (!stall_id_i && !exc.special_req && irq.handle_irq) begin
          state_d  = IRQ_TAKEN;
          halt_if  = 1'b1;
          flush_id = 1'b1;
        end
      end
      IRQ_TAKEN: begin
        pc_mux_o     = PC_EXC;
        exc_pc_mux_o = EXC_PC_IRQ;
        if (irq.handle_irq) begin
          pc_set_o         = 1'b1;
          csr_save_if_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = irq.irq_cause.raw;
          if (irq.irq_cause.raw == IRQ_NM) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = DECODE;
      end
      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;
        if (exc.exc_req_q) begin
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          exc_pc_mux_o     = EXC_PC_EXC;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          // fetch fault first as in the privileged spec
          if (exc.fetch_err) begin
            exc_cause_o = INSTR_ACCESS_FAULT;
            csr_mtval_o = pc_id_i;
          end else if (exc.illegal_q) begin
            exc_cause_o = ILLEGAL_INSN;
            csr_mtval_o = instr_i;
          end else if (exc.ecall) begin
            exc_cause_o = (priv_mode_i == PRIV_LVL_M) ? ECALL_MMODE : ECALL_UMODE;
          end else begin
            exc_cause_o = BREAKPOINT;
          end
        end else if (exc.mret) begin
          pc_set_o           = 1'b1;
          pc_mux_o           = PC_ERET;
          csr_restore_mret_o = 1'b1;
          // leaving the handler ends NMI mode
          nmi_mode_d         = 1'b0;
        end else if (exc.wfi) begin
          state_d = WAIT_SLEEP;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////
  // stall and flush
  ////////////////////////////////

  assign id_in_ready_o       = ~(stall_id_i | halt_if);
  // halted instruction stays valid unless flushed
  assign instr_valid_clear_o = ~(stall_id_i | halt_if) | flush_id;
  assign flush_id_o          = flush_id;

  assign exc.state    = state_q;
  assign irq.nmi_mode = nmi_mode_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

endmodule

// File: hdl/ctrl_irq_if.sv
/*
 * interrupt bus between the priority logic and the controller FSM
 */

`timescale 1ns/1ps

interface ctrl_irq_if;
  import ctrl_pkg::*;

  // take an interrupt now
  logic       handle_irq;
  // cause of the winning interrupt
  exc_cause_u irq_cause;
  // NMI handler running so further NMIs are masked
  logic       nmi_mode;

  modport prio (
    output handle_irq, irq_cause,
    input  nmi_mode
  );

  modport fsm (
    input  handle_irq, irq_cause,
    output nmi_mode
  );

endinterface

// File: hdl/ctrl_irq_prio.sv
/*
 * interrupt priority logic
 * decides whether an interrupt is taken and picks its cause code
 */

`timescale 1ns/1ps

module ctrl_irq_prio (
  input  logic                      csr_mstatus_mie_i,
  input  logic                      csr_msip_i,
  input  logic                      csr_mtip_i,
  input  logic                      csr_meip_i,
  input  logic [ctrl_pkg::nfast-1:0] csr_mfip_i,
  input  logic                      irq_nm_i,
  ctrl_irq_if.prio                  irq
);
  import ctrl_pkg::*;

  logic       irq_pending;
  logic       nmi_take;
  logic       fast_any;
  logic [3:0] mfip_id;
  exc_cause_u cause_u;

  // pending summary of bits that arrive already masked by mie
  assign fast_any    = |csr_mfip_i;
  assign irq_pending = csr_msip_i | csr_mtip_i | csr_meip_i | fast_any;

  // no nested NMI while its handler runs
  assign nmi_take = irq_nm_i & ~irq.nmi_mode;

  assign irq.handle_irq = nmi_take | (irq_pending & csr_mstatus_mie_i);

  // highest numbered fast irq wins as later hits override
  always_comb begin
    mfip_id = 4'd0;
    for (int i = 0; i < nfast; i++) begin
      if (csr_mfip_i[i]) begin
        mfip_id = 4'(i);
      end
    end
  end

  ////////////////////////////////
  // cause selection
  ////////////////////////////////

  always_comb begin
    cause_u.raw = IRQ_TIMER_M;
    if (nmi_take) begin
      cause_u.raw = IRQ_NM;
    end else if (fast_any) begin
      // interrupt bit plus fast bit puts cause at 16 + id
      cause_u.fields.irq  = 1'b1;
      cause_u.fields.fast = 1'b1;
      cause_u.fields.id   = mfip_id;
    end else if (csr_meip_i) begin
      cause_u.raw = IRQ_EXTERNAL_M;
    end else if (csr_msip_i) begin
      cause_u.raw = IRQ_SOFTWARE_M;
    end
    // timer is what is left
  end

  assign irq.irq_cause = cause_u;

endmodule

// File: hdl/ctrl_pkg.sv
/*
 * controller package
 * shared widths, FSM state, fetch select, privilege and trap cause types
 */

package ctrl_pkg;

  // datapath width and fast interrupt count
  parameter int unsigned xlen  = 32;
  parameter int unsigned nfast = 15;

  // controller states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_fsm_e;

  // fetch address select
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // trap vector select for a sync exception or an interrupt
  typedef enum logic {
    EXC_PC_EXC,
    EXC_PC_IRQ
  } exc_pc_sel_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // mcause codes with the top bit marking an interrupt
  typedef enum logic [5:0] {
    INSTR_ACCESS_FAULT = 6'd1,
    ILLEGAL_INSN       = 6'd2,
    BREAKPOINT         = 6'd3,
    ECALL_UMODE        = 6'd8,
    ECALL_MMODE        = 6'd11,
    IRQ_SOFTWARE_M     = 6'd35,
    IRQ_TIMER_M        = 6'd39,
    IRQ_EXTERNAL_M     = 6'd43,
    IRQ_NM             = 6'd63
  } exc_cause_e;

  // field view of a cause where fast irqs sit at 16 + id
  typedef struct packed {
    logic       irq;
    logic       fast;
    logic [3:0] id;
  } exc_cause_fields_t;

  typedef union packed {
    exc_cause_e        raw;
    exc_cause_fields_t fields;
  } exc_cause_u;

endpackage

// File: hdl/ctrl_top.sv
/*
 * controller top level
 * exception detector, interrupt priority and FSM joined by two buses
 */

`timescale 1ns/1ps

module ctrl_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        fetch_enable_i,
  output logic                        ctrl_busy_o,
  // decoder flags
  input  logic                        illegal_insn_i,
  input  logic                        ecall_insn_i,
  input  logic                        mret_insn_i,
  input  logic                        wfi_insn_i,
  input  logic                        ebrk_insn_i,
  // IF/ID register
  input  logic                        instr_valid_i,
  input  logic [ctrl_pkg::xlen-1:0]   instr_i,
  input  logic                        instr_fetch_err_i,
  input  logic [ctrl_pkg::xlen-1:0]   pc_id_i,
  output logic                        instr_valid_clear_o,
  output logic                        id_in_ready_o,
  // fetch control
  output logic                        instr_req_o,
  output logic                        pc_set_o,
  output ctrl_pkg::pc_sel_e           pc_mux_o,
  output ctrl_pkg::exc_pc_sel_e       exc_pc_mux_o,
  output ctrl_pkg::exc_cause_e        exc_cause_o,
  input  logic                        branch_set_i,
  input  logic                        jump_set_i,
  // interrupts
  input  logic                        csr_mstatus_mie_i,
  input  logic                        csr_msip_i,
  input  logic                        csr_mtip_i,
  input  logic                        csr_meip_i,
  input  logic [ctrl_pkg::nfast-1:0]  csr_mfip_i,
  input  logic                        irq_nm_i,
  output logic                        nmi_mode_o,
  // CSR side
  output logic                        csr_save_if_o,
  output logic                        csr_save_id_o,
  output logic                        csr_save_cause_o,
  output logic                        csr_restore_mret_o,
  output logic [ctrl_pkg::xlen-1:0]   csr_mtval_o,
  input  ctrl_pkg::priv_lvl_e         priv_mode_i,
  input  logic                        csr_mstatus_tw_i,
  // stall and flush
  input  logic                        stall_id_i,
  output logic                        flush_id_o
);

  logic csr_mip_any;

  ctrl_exc_if exc_bus ();
  ctrl_irq_if irq_bus ();

  // sleep wakeup ignores mie
  assign csr_mip_any = csr_msip_i | csr_mtip_i | csr_meip_i | (|csr_mfip_i);
  assign nmi_mode_o  = irq_bus.nmi_mode;

  ctrl_exc_detect u_exc_detect (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .illegal_insn_i    (illegal_insn_i),
    .ecall_insn_i      (ecall_insn_i),
    .mret_insn_i       (mret_insn_i),
    .wfi_insn_i        (wfi_insn_i),
    .ebrk_insn_i       (ebrk_insn_i),
    .instr_fetch_err_i (instr_fetch_err_i),
    .priv_mode_i       (priv_mode_i),
    .csr_mstatus_tw_i  (csr_mstatus_tw_i),
    .exc               (exc_bus.detector)
  );

  ctrl_irq_prio u_irq_prio (
    .csr_mstatus_mie_i (csr_mstatus_mie_i),
    .csr_msip_i        (csr_msip_i),
    .csr_mtip_i        (csr_mtip_i),
    .csr_meip_i        (csr_meip_i),
    .csr_mfip_i        (csr_mfip_i),
    .irq_nm_i          (irq_nm_i),
    .irq               (irq_bus.prio)
  );

  ctrl_fsm u_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_enable_i      (fetch_enable_i),
    .instr_valid_i       (instr_valid_i),
    .instr_i             (instr_i),
    .pc_id_i             (pc_id_i),
    .priv_mode_i         (priv_mode_i),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .stall_id_i          (stall_id_i),
    .irq_nm_i            (irq_nm_i),
    .csr_mip_any_i       (csr_mip_any),
    .exc                 (exc_bus.fsm),
    .irq                 (irq_bus.fsm),
    .ctrl_busy_o         (ctrl_busy_o),
    .instr_req_o         (instr_req_o),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .exc_pc_mux_o        (exc_pc_mux_o),
    .exc_cause_o         (exc_cause_o),
    .csr_save_if_o       (csr_save_if_o),
    .csr_save_id_o       (csr_save_id_o),
    .csr_save_cause_o    (csr_save_cause_o),
    .csr_restore_mret_o  (csr_restore_mret_o),
    .csr_mtval_o         (csr_mtval_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o)
  );

endmodule

// File: run.sh
#!/bin/sh
# build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ctrl_top -f flist.f -o sim_ctrl_top

out=$(./obj_dir/sim_ctrl_top)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
else
  exit 1
fi

// File: sim/ctrl_assertions.sv
/*
 * concurrent checks on the controller FSM, bound into every ctrl_fsm
 */

`timescale 1ns/1ps

module ctrl_assertions (
  input logic       clk_i,
  input logic       rst_ni,
  input logic [3:0] state_i,
  input logic       pc_set_i,
  input logic       csr_save_cause_i,
  input logic       ctrl_busy_i
);
  import ctrl_pkg::*;

  // only the eight encoded states
  state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i <= 4'(IRQ_TAKEN)) else $error("FSM in an unused state");

  // an interrupt redirect always records its cause
  irq_saves_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == 4'(IRQ_TAKEN) && pc_set_i) |-> csr_save_cause_i)
    else $error("interrupt taken without cause save");

  idle_in_wait_sleep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == 4'(WAIT_SLEEP)) |-> !ctrl_busy_i) else $error("busy while going to sleep");

endmodule

bind ctrl_fsm ctrl_assertions u_assertions (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .state_i          (state_q),
  .pc_set_i         (pc_set_o),
  .csr_save_cause_i (csr_save_cause_o),
  .ctrl_busy_i      (ctrl_busy_o)
);

// File: sim/tb_ctrl_top.sv
/*
 * testbench for the controller top level
 * random decoder, CSR and interrupt stimulus checked cycle by cycle against a model
 */

`timescale 1ns/1ps

module tb_ctrl_top;
  import ctrl_pkg::*;

  localparam int unsigned num_cycles = 3000;
  localparam int unsigned idle_limit = 300;

  logic              clk_i;
  logic              rst_ni;
  logic              fetch_enable_i;
  logic              ctrl_busy_o;
  logic              illegal_insn_i;
  logic              ecall_insn_i;
  logic              mret_insn_i;
  logic              wfi_insn_i;
  logic              ebrk_insn_i;
  logic              instr_valid_i;
  logic [xlen-1:0]   instr_i;
  logic              instr_fetch_err_i;
  logic [xlen-1:0]   pc_id_i;
  logic              instr_valid_clear_o;
  logic              id_in_ready_o;
  logic              instr_req_o;
  logic              pc_set_o;
  pc_sel_e           pc_mux_o;
  exc_pc_sel_e       exc_pc_mux_o;
  exc_cause_e        exc_cause_o;
  logic              branch_set_i;
  logic              jump_set_i;
  logic              csr_mstatus_mie_i;
  logic              csr_msip_i;
  logic              csr_mtip_i;
  logic              csr_meip_i;
  logic [nfast-1:0]  csr_mfip_i;
  logic              irq_nm_i;
  logic              nmi_mode_o;
  logic              csr_save_if_o;
  logic              csr_save_id_o;
  logic              csr_save_cause_o;
  logic              csr_restore_mret_o;
  logic [xlen-1:0]   csr_mtval_o;
  priv_lvl_e         priv_mode_i;
  logic              csr_mstatus_tw_i;
  logic              stall_id_i;
  logic              flush_id_o;

  // model state and its next value
  ctrl_fsm_e   m_state, n_state;
  logic        m_nmi, n_nmi;
  logic        m_exc_q, n_exc_q;
  logic        m_ill_q, n_ill_q;

  // predicted outputs for the current cycle
  logic        e_busy, e_req, e_pc_set, e_save_if, e_save_id, e_save_cause, e_restore;
  logic        e_ready, e_clear, e_flush;
  logic [1:0]  e_pc_mux;
  logic        e_exc_pc_mux;
  logic [5:0]  e_cause;
  logic [31:0] e_mtval;

  int unsigned errors;
  int unsigned checks;
  int unsigned idle;
  logic        timed_out;

  ctrl_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // reference model of the controller rules on this cycle's inputs
  task automatic predict();
    logic       ecall, ebrk, mret, wfi, ferr, ill, umode, in_flush;
    logic       ill_d, exc_d, special, nmi_take, pend, handle, halt;
    logic [5:0] irq_cause;
    ecall    = ecall_insn_i & instr_valid_i;
    ebrk     = ebrk_insn_i & instr_valid_i;
    mret     = mret_insn_i & instr_valid_i;
    wfi      = wfi_insn_i & instr_valid_i;
    ferr     = instr_fetch_err_i & instr_valid_i;
    ill      = illegal_insn_i & instr_valid_i;
    umode    = (priv_mode_i != PRIV_LVL_M) & (mret | (csr_mstatus_tw_i & wfi));
    in_flush = (m_state == FLUSH);
    ill_d    = (ill | umode) & ~in_flush;
    exc_d    = (ecall | ebrk | ferr | ill_d) & ~in_flush;
    special  = mret | wfi | exc_d;
    nmi_take = irq_nm_i & ~m_nmi;
    pend     = csr_msip_i | csr_mtip_i | csr_meip_i | (|csr_mfip_i);
    handle   = nmi_take | (pend & csr_mstatus_mie_i);
    // NMI first, then fast 14 down to 0, external, software and timer
    irq_cause = 6'd39;
    if (nmi_take) begin
      irq_cause = 6'd63;
    end else if (|csr_mfip_i) begin
      for (int i = 0; i < nfast; i++) begin
        if (csr_mfip_i[i]) irq_cause = 6'd48 + 6'(i);
      end
    end else if (csr_meip_i) begin
      irq_cause = 6'd43;
    end else if (csr_msip_i) begin
      irq_cause = 6'd35;
    end
    n_state = m_state;
    n_nmi = m_nmi;
    e_busy = 1'b1;
    e_req = 1'b1;
    e_pc_set = 1'b0;
    e_pc_mux = PC_BOOT;
    e_exc_pc_mux = EXC_PC_IRQ;
    e_cause = 6'd0;
    e_mtval = '0;
    e_save_if = 1'b0;
    e_save_id = 1'b0;
    e_save_cause = 1'b0;
    e_restore = 1'b0;
    halt = 1'b0;
    e_flush = 1'b0;
    case (m_state)
      RESET: begin
        e_req = 1'b0;
        e_pc_set = 1'b1;
        if (fetch_enable_i) n_state = BOOT_SET;
      end
      BOOT_SET: begin
        e_pc_set = 1'b1;
        n_state = FIRST_FETCH;
      end
      WAIT_SLEEP: begin
        e_busy = 1'b0;
        e_req = 1'b0;
        halt = 1'b1;
        e_flush = 1'b1;
        n_state = SLEEP;
      end
      SLEEP: begin
        e_req = 1'b0;
        halt = 1'b1;
        e_flush = 1'b1;
        if (irq_nm_i || pend) n_state = FIRST_FETCH;
        else e_busy = 1'b0;
      end
      FIRST_FETCH: begin
        if (!stall_id_i) n_state = DECODE;
        if (handle) begin
          n_state = IRQ_TAKEN;
          halt = 1'b1;
          e_flush = 1'b1;
        end
      end
      DECODE: begin
        e_pc_mux = PC_JUMP;
        if (special) begin
          n_state = FLUSH;
          halt = 1'b1;
        end else if (instr_valid_i && (branch_set_i || jump_set_i)) begin
          e_pc_set = 1'b1;
        end
        // interrupt held off by back-pressure
        if (instr_valid_i && handle && stall_id_i) halt = 1'b1;
        if (!stall_id_i && !special && handle) begin
          n_state = IRQ_TAKEN;
          halt = 1'b1;
          e_flush = 1'b1;
        end
      end
      IRQ_TAKEN: begin
        e_pc_mux = PC_EXC;
        if (handle) begin
          e_pc_set = 1'b1;
          e_save_if = 1'b1;
          e_save_cause = 1'b1;
          e_cause = irq_cause;
          if (irq_cause == 6'd63) n_nmi = 1'b1;
        end
        n_state = DECODE;
      end
      default: begin
        // FLUSH
        halt = 1'b1;
        e_flush = 1'b1;
        n_state = DECODE;
        if (m_exc_q) begin
          e_pc_set = 1'b1;
          e_pc_mux = PC_EXC;
          e_exc_pc_mux = EXC_PC_EXC;
          e_save_id = 1'b1;
          e_save_cause = 1'b1;
          if (ferr) begin
            e_cause = 6'd1;
            e_mtval = pc_id_i;
          end else if (m_ill_q) begin
            e_cause = 6'd2;
            e_mtval = instr_i;
          end else if (ecall) begin
            e_cause = (priv_mode_i == PRIV_LVL_M) ? 6'd11 : 6'd8;
          end else begin
            e_cause = 6'd3;
          end
        end else if (mret) begin
          e_pc_set = 1'b1;
          e_pc_mux = PC_ERET;
          e_restore = 1'b1;
          n_nmi = 1'b0;
        end else if (wfi) begin
          n_state = WAIT_SLEEP;
        end
      end
    endcase
    e_ready = ~(stall_id_i | halt);
    e_clear = e_ready | e_flush;
    n_exc_q = exc_d;
    n_ill_q = ill_d;
  endtask

  task automatic compare_outputs();
    check_value("ctrl_busy_o", ctrl_busy_o, e_busy);
    check_value("instr_req_o", instr_req_o, e_req);
    check_value("pc_set_o", pc_set_o, e_pc_set);
    check_value("pc_mux_o", pc_mux_o, e_pc_mux);
    check_value("exc_pc_mux_o", exc_pc_mux_o, e_exc_pc_mux);
    check_value("exc_cause_o", exc_cause_o, e_cause);
    check_value("csr_mtval_o", csr_mtval_o, e_mtval);
    check_value("csr_save_if_o", csr_save_if_o, e_save_if);
    check_value("csr_save_id_o", csr_save_id_o, e_save_id);
    check_value("csr_save_cause_o", csr_save_cause_o, e_save_cause);
    check_value("csr_restore_mret_o", csr_restore_mret_o, e_restore);
    check_value("id_in_ready_o", id_in_ready_o, e_ready);
    check_value("instr_valid_clear_o", instr_valid_clear_o, e_clear);
    check_value("flush_id_o", flush_id_o, e_flush);
    check_value("nmi_mode_o", nmi_mode_o, m_nmi);
  endtask

  // new random inputs while the instruction stays in ID until cleared
  task automatic drive_inputs();
    if (!(instr_valid_i && !e_clear)) begin
      instr_valid_i     <= ($urandom % 10) < 7;
      illegal_insn_i    <= ($urandom % 12) == 0;
      ecall_insn_i      <= ($urandom % 12) == 0;
      mret_insn_i       <= ($urandom % 12) == 0;
      wfi_insn_i        <= ($urandom % 14) == 0;
      ebrk_insn_i       <= ($urandom % 12) == 0;
      instr_fetch_err_i <= ($urandom % 16) == 0;
      branch_set_i      <= ($urandom % 6) == 0;
      jump_set_i        <= ($urandom % 8) == 0;
      instr_i           <= $urandom;
      pc_id_i           <= $urandom;
      priv_mode_i       <= ($urandom % 2) ? PRIV_LVL_M : PRIV_LVL_U;
    end
    stall_id_i        <= ($urandom % 4) == 0;
    csr_mstatus_mie_i <= ($urandom % 10) < 7;
    csr_mstatus_tw_i  <= $urandom % 2;
    csr_msip_i        <= ($urandom % 30) == 0;
    csr_mtip_i        <= ($urandom % 30) == 0;
    csr_meip_i        <= ($urandom % 30) == 0;
    csr_mfip_i        <= (($urandom % 20) == 0) ? 15'($urandom) : '0;
    irq_nm_i          <= ($urandom % 40) == 0;
  endtask

  initial begin
    void'($urandom(32'ha786_9f29));
    errors = 0;
    checks = 0;
    idle = 0;
    timed_out = 1'b0;
    rst_ni = 1'b0;
    fetch_enable_i = 1'b1;
    {illegal_insn_i, ecall_insn_i, mret_insn_i, wfi_insn_i, ebrk_insn_i} = '0;
    {instr_valid_i, instr_fetch_err_i, branch_set_i, jump_set_i} = '0;
    instr_i = '0;
    pc_id_i = '0;
    {csr_mstatus_mie_i, csr_msip_i, csr_mtip_i, csr_meip_i, irq_nm_i} = '0;
    csr_mfip_i = '0;
    priv_mode_i = PRIV_LVL_M;
    csr_mstatus_tw_i = 1'b0;
    stall_id_i = 1'b0;
    m_state = RESET;
    m_nmi = 1'b0;
    m_exc_q = 1'b0;
    m_ill_q = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int unsigned cyc = 0; cyc < num_cycles; cyc++) begin
      @(negedge clk_i);
      predict();
      compare_outputs();
      // progress watchdog where a redirect, a consumed instruction or sleep counts
      if (e_pc_set || (instr_valid_i && e_ready) || !e_busy) idle = 0;
      else idle++;
      if (idle > idle_limit) begin
        $display("controller made no progress for %0d cycles", idle_limit);
        timed_out = 1'b1;
        break;
      end
      @(posedge clk_i);
      m_state = n_state;
      m_nmi = n_nmi;
      m_exc_q = n_exc_q;
      m_ill_q = n_ill_q;
      drive_inputs();
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
